/* source/fft_reorder_pkg.sv */
`default_nettype none

package fft_reorder_pkg;

  //--------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------

  // Largest supported frame is 2**6 = 64 bins
  localparam int MAX_FFT_LEN_LOG2 = 6;
  localparam int DATA_W           = 16;
  // One bank holds exactly one frame of the largest size
  localparam int ADDR_W           = MAX_FFT_LEN_LOG2;
  // One extra bit so the full frame length itself fits
  localparam int LEN_W            = MAX_FFT_LEN_LOG2 + 1;
  localparam int LEN_LOG2_W       = 3;
  localparam int CP_LEN_W         = ADDR_W;
  // Read array register plus output register of each bank
  localparam int READ_LATENCY     = 2;
  localparam int OUT_FIFO_LOG2    = 3;
  // Beats the reader keeps free in the output FIFO for data in flight
  localparam int OUT_FIFO_RESERVE = 4;

  //--------------------------------------------------------------------
  // Types
  //--------------------------------------------------------------------

  typedef enum logic [1:0] {
    NORMAL,
    REVERSE,
    NATURAL,
    BIT_REVERSE
  } fft_order_t;

  // Configuration write from outside
  typedef struct packed {
    logic                  wr;
    logic [LEN_LOG2_W-1:0] len_log2;
    fft_order_t            order;
  } fft_cfg_t;

  // Frame size values derived once per configuration write
  typedef struct packed {
    logic [LEN_LOG2_W-1:0] len_log2;
    logic [LEN_W-1:0]      len;
    logic [LEN_W-1:0]      len_m1;
  } frame_len_t;

  // Input stream payload
  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [CP_LEN_W-1:0] cp_len;
    logic                last;
  } in_beat_t;

  // Output stream payload
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } out_beat_t;

  // Write request to the active write bank
  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              last;
  } ram_wr_t;

  // Read request to the active read bank
  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic              last;
  } ram_rd_t;

  // CP length taken from the first beat of a frame
  typedef struct packed {
    logic                valid;
    logic [CP_LEN_W-1:0] len;
  } cp_len_t;

endpackage

`default_nettype wire

/* source/fft_reorder_cfg.sv */
`timescale 1ns/100ps
`default_nettype none

module fft_reorder_cfg (
  input  wire                            clk,
  input  wire                            rst,
  input  wire fft_reorder_pkg::fft_cfg_t i_cfg,
  output logic                           o_cfg_stb,
  output fft_reorder_pkg::fft_order_t    o_order,
  output fft_reorder_pkg::frame_len_t    o_len
);

  // Frame length for the size being written
  logic [fft_reorder_pkg::LEN_W-1:0] len_nx;

  assign len_nx = fft_reorder_pkg::LEN_W'(1) << i_cfg.len_log2;

  // Configuration is only written while idle, so the writer and reader
  // simply pick up the new values together with the delayed strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      o_cfg_stb <= 1'b0;
      o_order   <= fft_reorder_pkg::NORMAL;
      // Default to the largest frame
      o_len.len_log2 <= fft_reorder_pkg::LEN_LOG2_W'(fft_reorder_pkg::MAX_FFT_LEN_LOG2);
      o_len.len      <= fft_reorder_pkg::LEN_W'(1) << fft_reorder_pkg::MAX_FFT_LEN_LOG2;
      o_len.len_m1   <= (fft_reorder_pkg::LEN_W'(1) << fft_reorder_pkg::MAX_FFT_LEN_LOG2) - 1'b1;
    end else begin
      o_cfg_stb <= i_cfg.wr;
      if (i_cfg.wr) begin
        o_order        <= i_cfg.order;
        o_len.len_log2 <= i_cfg.len_log2;
        o_len.len      <= len_nx;
        o_len.len_m1   <= len_nx - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/fft_reorder_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module fft_reorder_writer (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              i_cfg_stb,
  input  wire fft_reorder_pkg::fft_order_t i_order,
  input  wire fft_reorder_pkg::frame_len_t i_len,
  input  wire fft_reorder_pkg::in_beat_t   i_in_beat,
  input  wire                              i_in_valid,
  output logic                             o_in_ready,
  input  wire                              i_wr_ok,
  output fft_reorder_pkg::ram_wr_t         o_ram_wr,
  output fft_reorder_pkg::cp_len_t         o_cp_len
);

  // Reverse the low len_log2 bits of an address, upper bits end up zero
  function automatic logic [fft_reorder_pkg::ADDR_W-1:0] bit_rev(
    input logic [fft_reorder_pkg::ADDR_W-1:0]     val,
    input logic [fft_reorder_pkg::LEN_LOG2_W-1:0] len_log2
  );
    logic [fft_reorder_pkg::ADDR_W-1:0] full;
    for (int i = 0; i < fft_reorder_pkg::ADDR_W; i++) begin
      full[i] = val[fft_reorder_pkg::ADDR_W-1-i];
    end
    return full >> (fft_reorder_pkg::ADDR_W - len_log2);
  endfunction

  logic                               wr_en;
  logic                               first;
  logic [fft_reorder_pkg::ADDR_W-1:0] wr_count;
  logic [fft_reorder_pkg::ADDR_W-1:0] count_nx;
  logic [fft_reorder_pkg::ADDR_W-1:0] wr_addr;
  logic [fft_reorder_pkg::ADDR_W-1:0] addr_mask;
  logic [fft_reorder_pkg::ADDR_W-1:0] mask_nx;
  logic [fft_reorder_pkg::ADDR_W-1:0] nat_addr;

  // A beat is accepted whenever the current write bank is free
  assign o_in_ready = i_wr_ok;
  assign wr_en      = i_in_valid && i_wr_ok;
  assign count_nx   = wr_count + 1'b1;

  //--------------------------------------------------------------------
  // Address mask per output order
  //--------------------------------------------------------------------

  // Data is first brought to natural order, then the mask flips address
  // bits so a plain sequential read gives the wanted order
  always_comb begin
    unique case (i_order)
      // Flipping the MSB puts the negative bins first
      fft_reorder_pkg::NORMAL:  mask_nx = fft_reorder_pkg::ADDR_W'(i_len.len >> 1);
      // Flipping all bits below the MSB also runs each half backwards
      fft_reorder_pkg::REVERSE: mask_nx = fft_reorder_pkg::ADDR_W'(i_len.len_m1 >> 1);
      default:                  mask_nx = '0;
    endcase
  end

  // BIT_REVERSE output keeps the input order as it is
  assign nat_addr = (i_order == fft_reorder_pkg::BIT_REVERSE) ? count_nx :
                    bit_rev(count_nx, i_len.len_log2);

  //--------------------------------------------------------------------
  // Beat counter and write address
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      // Matches NORMAL order at the largest size after reset
      wr_count  <= '0;
      addr_mask <= {1'b1, {(fft_reorder_pkg::ADDR_W-1){1'b0}}};
      wr_addr   <= {1'b1, {(fft_reorder_pkg::ADDR_W-1){1'b0}}};
      first     <= 1'b1;
    end else if (i_cfg_stb) begin
      wr_count  <= '0;
      addr_mask <= mask_nx;
      wr_addr   <= mask_nx;
      first     <= 1'b1;
    end else if (wr_en) begin
      // The next beat after a last one starts a new frame
      first <= i_in_beat.last;
      if (i_in_beat.last) begin
        wr_count <= '0;
        wr_addr  <= addr_mask;
      end else begin
        wr_count <= count_nx;
        wr_addr  <= nat_addr ^ addr_mask;
      end
    end
  end

  assign o_ram_wr = '{
    en:   wr_en,
    addr: wr_addr,
    data: i_in_beat.data,
    last: i_in_beat.last
  };

  // CP length is only meaningful on the first beat of a frame
  assign o_cp_len = '{valid: wr_en && first, len: i_in_beat.cp_len};

endmodule

`default_nettype wire

/* source/fft_reorder_pingpong.sv */
`timescale 1ns/100ps
`default_nettype none

module fft_reorder_pingpong (
  input  wire                            clk,
  input  wire                            rst,
  input  wire fft_reorder_pkg::ram_wr_t  i_ram_wr,
  input  wire fft_reorder_pkg::ram_rd_t  i_ram_rd,
  output logic                           o_wr_ok,
  output logic                           o_rd_ok,
  output fft_reorder_pkg::out_beat_t     o_rd_beat,
  output logic                           o_rd_valid
);

  // Each bank stores one full frame
  logic [fft_reorder_pkg::DATA_W-1:0] bank0 [1 << fft_reorder_pkg::ADDR_W];
  logic [fft_reorder_pkg::DATA_W-1:0] bank1 [1 << fft_reorder_pkg::ADDR_W];

  // Bank pointers and ownership flags
  logic wr_bank;
  logic rd_bank;
  logic wr_ok;
  logic rd_ok;
  logic wr_done;
  logic rd_done;

  // Array read register and output register of each bank
  logic [fft_reorder_pkg::DATA_W-1:0] raw0;
  logic [fft_reorder_pkg::DATA_W-1:0] raw1;
  logic [fft_reorder_pkg::DATA_W-1:0] dout0;
  logic [fft_reorder_pkg::DATA_W-1:0] dout1;

  // Read controls delayed to line up with the bank outputs
  logic [fft_reorder_pkg::READ_LATENCY-1:0] en_del;
  logic [fft_reorder_pkg::READ_LATENCY-1:0] last_del;
  logic [fft_reorder_pkg::READ_LATENCY-1:0] bank_del;

  assign wr_done = i_ram_wr.en && i_ram_wr.last;
  assign rd_done = i_ram_rd.en && i_ram_rd.last;
  assign o_wr_ok = wr_ok;
  assign o_rd_ok = rd_ok;

  //--------------------------------------------------------------------
  // Banks
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (i_ram_wr.en && !wr_bank) begin
      bank0[i_ram_wr.addr] <= i_ram_wr.data;
    end
    if (i_ram_wr.en && wr_bank) begin
      bank1[i_ram_wr.addr] <= i_ram_wr.data;
    end
    // Both banks are read every cycle and the right one is picked later
    raw0  <= bank0[i_ram_rd.addr];
    raw1  <= bank1[i_ram_rd.addr];
    dout0 <= raw0;
    dout1 <= raw1;
    // Final select stage into the output FIFO
    o_rd_beat.data <= bank_del[fft_reorder_pkg::READ_LATENCY-1] ? dout1 : dout0;
    o_rd_beat.last <= last_del[fft_reorder_pkg::READ_LATENCY-1];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      en_del     <= '0;
      last_del   <= '0;
      bank_del   <= '0;
      o_rd_valid <= 1'b0;
    end else begin
      en_del     <= {en_del[fft_reorder_pkg::READ_LATENCY-2:0], i_ram_rd.en};
      last_del   <= {last_del[fft_reorder_pkg::READ_LATENCY-2:0], rd_done};
      bank_del   <= {bank_del[fft_reorder_pkg::READ_LATENCY-2:0], rd_bank};
      o_rd_valid <= en_del[fft_reorder_pkg::READ_LATENCY-1];
    end
  end

  //--------------------------------------------------------------------
  // Bank ownership
  //--------------------------------------------------------------------

  // Each pointer moves to the other bank once its frame is complete
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_bank <= 1'b0;
      rd_bank <= 1'b0;
    end else begin
      if (wr_done) begin
        wr_bank <= ~wr_bank;
      end
      if (rd_done) begin
        rd_bank <= ~rd_bank;
      end
    end
  end

  // Both banks start empty, so writing is allowed and reading is not
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ok <= 1'b1;
      rd_ok <= 1'b0;
    end else if (wr_done && rd_done) begin
      // Both sides swap banks together
      wr_ok <= 1'b1;
      rd_ok <= 1'b1;
    end else if (wr_done) begin
      if (wr_bank == rd_bank) begin
        // Reader was waiting on this bank and the other one is free
        wr_ok <= 1'b1;
        rd_ok <= 1'b1;
      end else begin
        // Writer moves onto the bank still being read
        wr_ok <= 1'b0;
      end
    end else if (rd_done) begin
      if (wr_bank == rd_bank) begin
        // Writer was blocked on this bank and the other one is full
        wr_ok <= 1'b1;
        rd_ok <= 1'b1;
      end else begin
        // Reader moves onto the bank still being written
        rd_ok <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/fft_reorder_reader.sv */
`timescale 1ns/100ps
`default_nettype none

module fft_reorder_reader (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire                                    i_cfg_stb,
  input  wire fft_reorder_pkg::frame_len_t       i_len,
  input  wire fft_reorder_pkg::cp_len_t          i_cp_len,
  input  wire                                    i_rd_ok,
  input  wire [fft_reorder_pkg::LEN_W-1:0]       i_space,
  output fft_reorder_pkg::ram_rd_t               o_ram_rd
);

  typedef enum logic [1:0] {
    WAIT_CP,
    READ_CP,
    READ_FRAME
  } rd_state_t;

  // Two frames fit in the banks, so two CP lengths are enough
  logic [fft_reorder_pkg::CP_LEN_W-1:0] q_len [2];
  logic                                 q_wr_ptr;
  logic                                 q_rd_ptr;
  logic [1:0]                           q_count;

  // Registered view of the queue head
  logic                                 cp_valid;
  logic                                 cp_nonzero;
  logic [fft_reorder_pkg::ADDR_W-1:0]   cp_start;
  logic                                 cp_consume;

  rd_state_t                            state;
  rd_state_t                            state_nx;
  logic [fft_reorder_pkg::ADDR_W-1:0]   rd_addr;
  logic [fft_reorder_pkg::ADDR_W-1:0]   rd_addr_nx;
  logic                                 rd_en;
  logic                                 rd_last;
  logic                                 space_ok;
  logic                                 at_end;

  //--------------------------------------------------------------------
  // CP length queue
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (i_cp_len.valid) begin
      q_len[q_wr_ptr] <= i_cp_len.len;
    end
    // The CP is read from the tail of the frame
    cp_start   <= fft_reorder_pkg::ADDR_W'(i_len.len - fft_reorder_pkg::LEN_W'(q_len[q_rd_ptr]));
    cp_nonzero <= q_len[q_rd_ptr] != '0;
  end

  always_ff @(posedge clk) begin
    if (rst || i_cfg_stb) begin
      q_wr_ptr <= 1'b0;
      q_rd_ptr <= 1'b0;
      q_count  <= '0;
      cp_valid <= 1'b0;
    end else begin
      if (i_cp_len.valid) begin
        q_wr_ptr <= ~q_wr_ptr;
      end
      if (cp_consume) begin
        q_rd_ptr <= ~q_rd_ptr;
      end
      q_count  <= q_count + 2'(i_cp_len.valid) - 2'(cp_consume);
      // Lags the queue by a cycle, far shorter than any frame read
      cp_valid <= (q_count != '0) && !cp_consume;
    end
  end

  //--------------------------------------------------------------------
  // Read state machine
  //--------------------------------------------------------------------

  assign at_end = {1'b0, rd_addr} == i_len.len_m1;
  // Reads only run while the bank holds a frame and the FIFO has room
  assign rd_en  = (state != WAIT_CP) && i_rd_ok && space_ok;

  always_comb begin
    state_nx   = state;
    rd_addr_nx = rd_addr;
    rd_last    = 1'b0;
    cp_consume = 1'b0;
    unique case (state)
      WAIT_CP: begin
        if (cp_valid) begin
          cp_consume = 1'b1;
          if (cp_nonzero) begin
            state_nx   = READ_CP;
            rd_addr_nx = cp_start;
          end else begin
            state_nx   = READ_FRAME;
            rd_addr_nx = '0;
          end
        end
      end
      READ_CP: begin
        // Prefix runs from the start address to the end of the frame
        if (rd_en) begin
          rd_addr_nx = at_end ? '0 : rd_addr + 1'b1;
          if (at_end) begin
            state_nx = READ_FRAME;
          end
        end
      end
      default: begin
        // Whole frame follows, and its final read frees the bank
        if (rd_en) begin
          rd_addr_nx = at_end ? '0 : rd_addr + 1'b1;
          if (at_end) begin
            rd_last  = 1'b1;
            state_nx = WAIT_CP;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || i_cfg_stb) begin
      state   <= WAIT_CP;
      rd_addr <= '0;
    end else begin
      state   <= state_nx;
      rd_addr <= rd_addr_nx;
    end
  end

  // Reserve covers the beats still in the read pipeline
  always_ff @(posedge clk) begin
    if (rst) begin
      space_ok <= 1'b0;
    end else begin
      space_ok <= i_space > fft_reorder_pkg::LEN_W'(fft_reorder_pkg::OUT_FIFO_RESERVE);
    end
  end

  assign o_ram_rd = '{en: rd_en, addr: rd_addr, last: rd_last};

endmodule

`default_nettype wire

/* source/fft_reorder_out_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module fft_reorder_out_fifo (
  input  wire                              clk,
  input  wire                              rst,
  input  wire fft_reorder_pkg::out_beat_t  i_beat,
  input  wire                              i_valid,
  output fft_reorder_pkg::out_beat_t       o_beat,
  output logic                             o_valid,
  input  wire                              i_ready,
  output logic [fft_reorder_pkg::LEN_W-1:0] o_space
);

  fft_reorder_pkg::out_beat_t mem [1 << fft_reorder_pkg::OUT_FIFO_LOG2];

  logic [fft_reorder_pkg::OUT_FIFO_LOG2-1:0] wr_ptr;
  logic [fft_reorder_pkg::OUT_FIFO_LOG2-1:0] rd_ptr;
  // Count of free entries, full depth when empty
  logic [fft_reorder_pkg::LEN_W-1:0]         free;
  logic                                      pop;

  // Head entry is shown as soon as it is written
  assign o_valid = free != fft_reorder_pkg::LEN_W'(1 << fft_reorder_pkg::OUT_FIFO_LOG2);
  assign o_beat  = mem[rd_ptr];
  assign o_space = free;
  assign pop     = o_valid && i_ready;

  // Writes never arrive while full since the reader keeps a reserve
  always_ff @(posedge clk) begin
    if (i_valid) begin
      mem[wr_ptr] <= i_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      free   <= fft_reorder_pkg::LEN_W'(1 << fft_reorder_pkg::OUT_FIFO_LOG2);
    end else begin
      if (i_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      free <= free - fft_reorder_pkg::LEN_W'(i_valid) + fft_reorder_pkg::LEN_W'(pop);
    end
  end

endmodule

`default_nettype wire

/* source/fft_reorder.sv */
`timescale 1ns/100ps
`default_nettype none

module fft_reorder (
  input  wire                             clk,
  input  wire                             rst,
  input  wire fft_reorder_pkg::fft_cfg_t  i_cfg,
  input  wire fft_reorder_pkg::in_beat_t  i_in_beat,
  input  wire                             i_in_valid,
  output logic                            o_in_ready,
  output fft_reorder_pkg::out_beat_t      o_out_beat,
  output logic                            o_out_valid,
  input  wire                             i_out_ready
);

  // Configuration to writer and reader
  logic                              cfg_stb;
  fft_reorder_pkg::fft_order_t       order;
  fft_reorder_pkg::frame_len_t       len;

  // Bank requests and ownership
  fft_reorder_pkg::ram_wr_t          ram_wr;
  fft_reorder_pkg::ram_rd_t          ram_rd;
  fft_reorder_pkg::cp_len_t          cp_len;
  logic                              wr_ok;
  logic                              rd_ok;

  // Read data into the output FIFO
  fft_reorder_pkg::out_beat_t        rd_beat;
  logic                              rd_valid;
  logic [fft_reorder_pkg::LEN_W-1:0] space;

  fft_reorder_cfg u_cfg (
    .clk       (clk),
    .rst       (rst),
    .i_cfg     (i_cfg),
    .o_cfg_stb (cfg_stb),
    .o_order   (order),
    .o_len     (len)
  );

  fft_reorder_writer u_writer (
    .clk        (clk),
    .rst        (rst),
    .i_cfg_stb  (cfg_stb),
    .i_order    (order),
    .i_len      (len),
    .i_in_beat  (i_in_beat),
    .i_in_valid (i_in_valid),
    .o_in_ready (o_in_ready),
    .i_wr_ok    (wr_ok),
    .o_ram_wr   (ram_wr),
    .o_cp_len   (cp_len)
  );

  fft_reorder_pingpong u_pingpong (
    .clk        (clk),
    .rst        (rst),
    .i_ram_wr   (ram_wr),
    .i_ram_rd   (ram_rd),
    .o_wr_ok    (wr_ok),
    .o_rd_ok    (rd_ok),
    .o_rd_beat  (rd_beat),
    .o_rd_valid (rd_valid)
  );

  fft_reorder_reader u_reader (
    .clk       (clk),
    .rst       (rst),
    .i_cfg_stb (cfg_stb),
    .i_len     (len),
    .i_cp_len  (cp_len),
    .i_rd_ok   (rd_ok),
    .i_space   (space),
    .o_ram_rd  (ram_rd)
  );

  fft_reorder_out_fifo u_out_fifo (
    .clk     (clk),
    .rst     (rst),
    .i_beat  (rd_beat),
    .i_valid (rd_valid),
    .o_beat  (o_out_beat),
    .o_valid (o_out_valid),
    .i_ready (i_out_ready),
    .o_space (space)
  );

endmodule

`default_nettype wire

/* verification/fft_reorder_tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module fft_reorder_tb_clock (
  output logic o_clk
);

  // Free running clock with a 100 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #50;
      o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire

/* verification/fft_reorder_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module fft_reorder_assertions (
  input wire                           clk,
  input wire                           rst,
  input wire fft_reorder_pkg::ram_wr_t i_ram_wr,
  input wire fft_reorder_pkg::ram_rd_t i_ram_rd,
  input wire                           i_wr_bank,
  input wire                           i_rd_bank,
  input wire                           i_wr_ok,
  input wire                           i_rd_ok
);

  // Failure count of each property
  int bank_fails = 0;
  int wr_fails   = 0;
  int rd_fails   = 0;

  // Writer and reader never work on the same bank in one cycle
  a_banks_apart: assert property (@(posedge clk) disable iff (rst)
    (i_ram_wr.en && i_ram_rd.en) |-> (i_wr_bank != i_rd_bank))
    else begin
      bank_fails++;
      $error("write and read hit the same bank in one cycle");
    end

  // A bank is written only while the writer owns a free bank
  a_write_owned: assert property (@(posedge clk) disable iff (rst)
    i_ram_wr.en |-> i_wr_ok)
    else begin
      wr_fails++;
      $error("bank written without write ownership");
    end

  // A bank is read only once it holds a complete frame
  a_read_owned: assert property (@(posedge clk) disable iff (rst)
    i_ram_rd.en |-> i_rd_ok)
    else begin
      rd_fails++;
      $error("bank read without read ownership");
    end

endmodule

bind fft_reorder_pingpong fft_reorder_assertions u_assertions (
  .clk       (clk),
  .rst       (rst),
  .i_ram_wr  (i_ram_wr),
  .i_ram_rd  (i_ram_rd),
  .i_wr_bank (wr_bank),
  .i_rd_bank (rd_bank),
  .i_wr_ok   (wr_ok),
  .i_rd_ok   (rd_ok)
);

`default_nettype wire

/* verification/fft_reorder_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fft_reorder_tb;

  //--------------------------------------------------------------------
  // Run length and watchdog
  //--------------------------------------------------------------------

  // Input beats over all tests, then the largest possible prefix total
  localparam int IN_BEATS      = 64 + 16 + 64 + 32 + 2 * 8 + 3 * 16 + 6 * 32;
  localparam int CP_BEATS_MAX  = 5 + 15 + 6 * 31;
  localparam int TOTAL_BEATS   = 2 * IN_BEATS + CP_BEATS_MAX;
  localparam int CLK_PERIOD_NS = 100;
  localparam int TIMEOUT_NS    = 4 * TOTAL_BEATS * CLK_PERIOD_NS + 50_000;

  logic                        clk;
  logic                        rst;
  fft_reorder_pkg::fft_cfg_t   cfg;
  fft_reorder_pkg::in_beat_t   in_beat;
  logic                        in_valid;
  logic                        in_ready;
  fft_reorder_pkg::out_beat_t  out_beat;
  logic                        out_valid;
  logic                        out_ready;
  // Turns on random output back-pressure
  logic                        random_ready;

  fft_reorder_pkg::out_beat_t  expected [$];
  fft_reorder_pkg::out_beat_t  collected [$];

  fft_reorder_tb_clock u_clock (
    .o_clk (clk)
  );

  fft_reorder u_dut (
    .clk         (clk),
    .rst         (rst),
    .i_cfg       (cfg),
    .i_in_beat   (in_beat),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .o_out_beat  (out_beat),
    .o_out_valid (out_valid),
    .i_out_ready (out_ready)
  );

  // Output ready is either held high or toggled at random
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #10;
      out_ready = random_ready ? ($urandom % 4 != 0) : 1'b1;
    end
  end

  // Valid and ready are both stable at the falling edge before a transfer
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      collected.push_back(out_beat);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: timeout, the output stream stopped before all frames arrived");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------

  function automatic int reverse_bits(input int val, input int width);
    int res;
    res = 0;
    for (int i = 0; i < width; i++) begin
      res = res | (((val >> i) & 1) << (width - 1 - i));
    end
    return res;
  endfunction

  // Bin shown at position k of a frame in the given output order
  function automatic int expected_bin(input fft_reorder_pkg::fft_order_t order,
                                      input int log2n, input int k);
    int n;
    n = 1 << log2n;
    case (order)
      fft_reorder_pkg::NATURAL: return k;
      fft_reorder_pkg::NORMAL:  return (k + n / 2) % n;
      fft_reorder_pkg::REVERSE: return (k < n / 2) ? n / 2 - 1 - k : n - 1 - (k - n / 2);
      default:                  return reverse_bits(k, log2n);
    endcase
  endfunction

  task automatic add_expected(input int tag, input fft_reorder_pkg::fft_order_t order,
                              input int log2n, input int cp);
    int                         n;
    int                         seq [64];
    int                         bin;
    fft_reorder_pkg::out_beat_t beat;
    n = 1 << log2n;
    for (int k = 0; k < n; k++) begin
      seq[k] = expected_bin(order, log2n, k);
    end
    // The prefix repeats the tail of the ordered frame
    for (int k = 0; k < cp + n; k++) begin
      bin       = (k < cp) ? seq[n - cp + k] : seq[k - cp];
      beat.data = fft_reorder_pkg::DATA_W'(tag * 256 + bin);
      beat.last = (k == cp + n - 1);
      expected.push_back(beat);
    end
  endtask

  //--------------------------------------------------------------------
  // Stimulus and checking
  //--------------------------------------------------------------------

  task automatic check_value(input logic [31:0] expected_val, input logic [31:0] actual_val,
                             input string what);
    if (expected_val !== actual_val) begin
      $display("MISMATCH at %0t ns: %s, expected %0h, got %0h",
               $time, what, expected_val, actual_val);
      $display("sim failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic configure(input fft_reorder_pkg::fft_order_t order, input int log2n);
    cfg = '{wr: 1'b1, len_log2: fft_reorder_pkg::LEN_LOG2_W'(log2n), order: order};
    @(posedge clk);
    #10;
    cfg.wr = 1'b0;
    // New values reach the writer and reader one cycle later
    repeat (2) begin
      @(posedge clk);
      #10;
    end
  endtask

  // Holds the beat until a rising edge sees ready high
  task automatic push_beat(input fft_reorder_pkg::in_beat_t beat);
    logic accepted;
    accepted = 1'b0;
    in_beat  = beat;
    in_valid = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      @(posedge clk);
      #10;
    end
    in_valid = 1'b0;
  endtask

  // Beat j carries bin bitrev(j), as an FFT core delivers it
  task automatic send_frame(input int tag, input int log2n, input int cp, input logic gaps);
    int                        n;
    fft_reorder_pkg::in_beat_t beat;
    n = 1 << log2n;
    for (int j = 0; j < n; j++) begin
      if (gaps && ($urandom % 4 == 0)) begin
        @(posedge clk);
        #10;
      end
      beat.data   = fft_reorder_pkg::DATA_W'(tag * 256 + reverse_bits(j, log2n));
      beat.cp_len = fft_reorder_pkg::CP_LEN_W'(cp);
      beat.last   = (j == n - 1);
      push_beat(beat);
    end
  endtask

  task automatic run_frame(input int tag, input fft_reorder_pkg::fft_order_t order,
                           input int log2n, input int cp, input logic gaps);
    add_expected(tag, order, log2n, cp);
    send_frame(tag, log2n, cp, gaps);
  endtask

  // Waits for every expected beat, then compares them in order
  task automatic compare_output(input string name);
    int                         count;
    fft_reorder_pkg::out_beat_t got;
    count = expected.size();
    while (collected.size() < count) begin
      @(posedge clk);
    end
    // Any extra beat stays queued and lands in front of the next test
    for (int i = 0; i < count; i++) begin
      got = collected.pop_front();
      check_value(32'(expected[i].data), 32'(got.data),
                  $sformatf("%s beat %0d data", name, i));
      check_value(32'(expected[i].last), 32'(got.last),
                  $sformatf("%s beat %0d last", name, i));
    end
    expected.delete();
    @(posedge clk);
    #10;
  endtask

  //--------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------

  task automatic natural_order_frame();
    configure(fft_reorder_pkg::NATURAL, 6);
    run_frame(1, fft_reorder_pkg::NATURAL, 6, 0, 1'b0);
    compare_output("natural 64");
  endtask

  // The size change between frames is checked here too
  task automatic normal_order_sizes();
    configure(fft_reorder_pkg::NORMAL, 4);
    run_frame(2, fft_reorder_pkg::NORMAL, 4, 0, 1'b0);
    compare_output("normal 16");
    configure(fft_reorder_pkg::NORMAL, 6);
    run_frame(3, fft_reorder_pkg::NORMAL, 6, 0, 1'b0);
    compare_output("normal 64");
  endtask

  task automatic reverse_order_frame();
    configure(fft_reorder_pkg::REVERSE, 5);
    run_frame(4, fft_reorder_pkg::REVERSE, 5, 0, 1'b0);
    compare_output("reverse 32");
  endtask

  task automatic bit_reverse_frames();
    configure(fft_reorder_pkg::BIT_REVERSE, 3);
    run_frame(5, fft_reorder_pkg::BIT_REVERSE, 3, 0, 1'b0);
    run_frame(6, fft_reorder_pkg::BIT_REVERSE, 3, 0, 1'b0);
    compare_output("bit reverse 8");
  endtask

  task automatic cp_lengths_back_to_back();
    configure(fft_reorder_pkg::NORMAL, 4);
    run_frame(7, fft_reorder_pkg::NORMAL, 4, 0, 1'b0);
    run_frame(8, fft_reorder_pkg::NORMAL, 4, 5, 1'b0);
    run_frame(9, fft_reorder_pkg::NORMAL, 4, 15, 1'b0);
    compare_output("cp lengths");
  endtask

  task automatic random_flow_control();
    int cp;
    configure(fft_reorder_pkg::NORMAL, 5);
    random_ready = 1'b1;
    for (int f = 0; f < 6; f++) begin
      cp = int'($urandom % 32);
      run_frame(10 + f, fft_reorder_pkg::NORMAL, 5, cp, 1'b1);
    end
    compare_output("random flow");
    random_ready = 1'b0;
  endtask

  initial begin
    int assert_fails;
    void'($urandom(365));
    random_ready = 1'b0;
    rst          = 1'b1;
    cfg          = '0;
    in_beat      = '0;
    in_valid     = 1'b0;
    repeat (16) begin
      @(posedge clk);
    end
    #10;
    rst = 1'b0;
    @(posedge clk);
    #10;

    // Both banks start free and the output FIFO starts empty
    check_value(32'd1, 32'(in_ready), "input ready after reset");
    check_value(32'd0, 32'(out_valid), "output valid after reset");

    natural_order_frame();
    normal_order_sizes();
    reverse_order_frame();
    bit_reverse_frames();
    cp_lengths_back_to_back();
    random_flow_control();

    // Nothing may follow the last expected frame
    repeat (20) begin
      @(posedge clk);
    end
    check_value(32'd0, 32'(collected.size()), "beats left after the last test");

    assert_fails = u_dut.u_pingpong.u_assertions.bank_fails +
                   u_dut.u_pingpong.u_assertions.wr_fails +
                   u_dut.u_pingpong.u_assertions.rd_fails;
    if (assert_fails != 0) begin
      $display("ERROR: %0d bank ownership assertions failed", assert_fails);
      $display("sim failed");
      $fatal(1, "assertion failures during the run");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* fft_reorder.f */
source/fft_reorder_pkg.sv
source/fft_reorder_cfg.sv
source/fft_reorder_writer.sv
source/fft_reorder_pingpong.sv
source/fft_reorder_reader.sv
source/fft_reorder_out_fifo.sv
source/fft_reorder.sv
verification/fft_reorder_tb_clock.sv
verification/fft_reorder_assertions.sv
verification/fft_reorder_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fft_reorder testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fft_reorder_sim

verilator --binary --timing --assert -Wno-fatal \
  -f fft_reorder.f --top-module fft_reorder_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$("./$BUILD_DIR/$SIM_BIN")
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
